// ==== src/board_io_cfg.svh ====
`ifndef BOARD_IO_CFG_SVH
`define BOARD_IO_CFG_SVH

// stable cycles before a synchronized input is accepted.
`define BOARD_IO_DEBOUNCE_CYCLES 8

// memory-mapped word addresses of the board registers.
`define BOARD_IO_ADDR_RED_LEDS   32'h1f80_0000
`define BOARD_IO_ADDR_GREEN_LEDS 32'h1f80_0004
`define BOARD_IO_ADDR_SWITCHES   32'h1f80_0008
`define BOARD_IO_ADDR_BUTTONS    32'h1f80_000c

// led register widths.
`define BOARD_IO_RED_WIDTH   18
`define BOARD_IO_GREEN_WIDTH 9

`endif

// ==== src/board_io_pkg.sv ====
package board_io_pkg;

    // slide switches, 1 means up.
    typedef logic [9:0] sw_t;

    // push keys, active low at the pins.
    typedef logic [3:0] key_t;

    // one digit, segments g down to a, active low.
    typedef logic [6:0] seg_t;

    // the six digits of the display, leftmost first.
    typedef struct packed {
        seg_t digit5;
        seg_t digit4;
        seg_t digit3;
        seg_t digit2;
        seg_t digit1;
        seg_t digit0;
    } hex_t;

endpackage

// ==== src/io_bus_pkg.sv ====
package io_bus_pkg;

    // one processor request, taken whenever valid is high.
    typedef struct packed {
        logic        valid;
        logic        write;
        logic [31:0] addr;
        logic [31:0] wdata;
    } bus_req_t;

    // debounced inputs as seen by the register stage.
    typedef struct packed {
        board_io_pkg::sw_t  sw;
        board_io_pkg::key_t key;
    } input_sample_t;

endpackage

// ==== src/input_debouncer.sv ====
`timescale 1ns/1ps
`include "board_io_cfg.svh"

module input_debouncer #(
    parameter type payload_t = board_io_pkg::sw_t
) (
    input  logic     clk,
    input  logic     rst,
    input  payload_t raw,
    output payload_t clean
);

    localparam int WIDTH  = $bits(payload_t);
    localparam int CYCLES = `BOARD_IO_DEBOUNCE_CYCLES;
    localparam int CNT_W  = $clog2(CYCLES + 1);

    logic [WIDTH-1:0]            sync_meta;
    logic [WIDTH-1:0]            sync_stable;
    logic [WIDTH-1:0]            clean_bits;
    logic [WIDTH-1:0][CNT_W-1:0] stable_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            sync_meta   <= '0;
            sync_stable <= '0;
            clean_bits  <= '0;
            stable_cnt  <= '0;
        end else begin
            sync_meta   <= raw;
            sync_stable <= sync_meta;
            // each bit counts its own run of cycles away from clean.
            for (int i = 0; i < WIDTH; i++) begin
                if (sync_stable[i] == clean_bits[i]) begin
                    stable_cnt[i] <= '0;
                end else if (stable_cnt[i] == CNT_W'(CYCLES - 1)) begin
                    stable_cnt[i] <= '0;
                    clean_bits[i] <= sync_stable[i];
                end else begin
                    stable_cnt[i] <= stable_cnt[i] + 1'b1;
                end
            end
        end
    end

    assign clean = payload_t'(clean_bits);

endmodule

// ==== src/io_register_file.sv ====
`timescale 1ns/1ps
`include "board_io_cfg.svh"

module io_register_file (
    input  logic                             clk,
    input  logic                             rst,
    input  io_bus_pkg::bus_req_t             bus_req,
    input  io_bus_pkg::input_sample_t        sample,
    output logic [31:0]                      rd_data,
    output logic                             rd_valid,
    output logic [`BOARD_IO_RED_WIDTH-1:0]   red_leds,
    output logic [`BOARD_IO_GREEN_WIDTH-1:0] green_leds,
    output logic [3:0]                       addr_nibble
);

    localparam int SW_W  = $bits(board_io_pkg::sw_t);
    localparam int KEY_W = $bits(board_io_pkg::key_t);

    logic             hit_red;
    logic             hit_green;
    logic             hit_switches;
    logic             hit_buttons;
    logic [KEY_W-1:0] buttons;
    logic [31:0]      read_word;

    assign hit_red      = bus_req.addr == `BOARD_IO_ADDR_RED_LEDS;
    assign hit_green    = bus_req.addr == `BOARD_IO_ADDR_GREEN_LEDS;
    assign hit_switches = bus_req.addr == `BOARD_IO_ADDR_SWITCHES;
    assign hit_buttons  = bus_req.addr == `BOARD_IO_ADDR_BUTTONS;

    // pressed reads as 1 on the bus.
    assign buttons = ~sample.key;

    always_comb begin
        if (hit_red) begin
            read_word = {{(32 - `BOARD_IO_RED_WIDTH){1'b0}}, red_leds};
        end else if (hit_green) begin
            read_word = {{(32 - `BOARD_IO_GREEN_WIDTH){1'b0}}, green_leds};
        end else if (hit_switches) begin
            read_word = {{(32 - SW_W){1'b0}}, sample.sw};
        end else if (hit_buttons) begin
            read_word = {{(32 - KEY_W){1'b0}}, buttons};
        end else begin
            read_word = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            red_leds    <= '0;
            green_leds  <= '0;
            addr_nibble <= '0;
            rd_valid    <= 1'b0;
            rd_data     <= '0;
        end else begin
            rd_valid <= bus_req.valid && !bus_req.write;
            if (bus_req.valid) begin
                // any accepted request moves the digit5 nibble.
                addr_nibble <= bus_req.addr[31:28];
                if (bus_req.write) begin
                    if (hit_red) begin
                        red_leds <= bus_req.wdata[`BOARD_IO_RED_WIDTH-1:0];
                    end
                    if (hit_green) begin
                        green_leds <= bus_req.wdata[`BOARD_IO_GREEN_WIDTH-1:0];
                    end
                end else begin
                    rd_data <= read_word;
                end
            end
        end
    end

endmodule

// ==== src/seven_segment_bank.sv ====
`timescale 1ns/1ps
`include "board_io_cfg.svh"

module seven_segment_bank (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [`BOARD_IO_RED_WIDTH-1:0] red_leds,
    input  logic [3:0]                     addr_nibble,
    output board_io_pkg::hex_t             hex
);

    localparam board_io_pkg::seg_t GLYPH_ZERO = 7'b100_0000;

    board_io_pkg::hex_t hex_next;

    // hex digit to active-low segments, gfedcba.
    function automatic board_io_pkg::seg_t glyph(input logic [3:0] nib);
        case (nib)
            4'h0: return 7'b100_0000;
            4'h1: return 7'b111_1001;
            4'h2: return 7'b010_0100;
            4'h3: return 7'b011_0000;
            4'h4: return 7'b001_1001;
            4'h5: return 7'b001_0010;
            4'h6: return 7'b000_0010;
            4'h7: return 7'b111_1000;
            4'h8: return 7'b000_0000;
            4'h9: return 7'b001_0000;
            4'ha: return 7'b000_1000;
            4'hb: return 7'b000_0011;
            4'hc: return 7'b100_0110;
            4'hd: return 7'b010_0001;
            4'he: return 7'b000_0110;
            default: return 7'b000_1110;
        endcase
    endfunction

    // board layout, address nibble on the left.
    always_comb begin
        hex_next.digit5 = glyph(addr_nibble);
        hex_next.digit4 = glyph({2'b00, red_leds[17:16]});
        hex_next.digit3 = glyph(red_leds[15:12]);
        hex_next.digit2 = glyph(red_leds[11:8]);
        hex_next.digit1 = glyph(red_leds[7:4]);
        hex_next.digit0 = glyph(red_leds[3:0]);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hex <= '{default: GLYPH_ZERO};
        end else begin
            hex <= hex_next;
        end
    end

endmodule

// ==== src/de0_cv_io.sv ====
`timescale 1ns/1ps
`include "board_io_cfg.svh"

module de0_cv_io (
    input  logic                 clk,
    input  logic                 rst,
    input  board_io_pkg::sw_t    sw,
    input  board_io_pkg::key_t   key,
    input  io_bus_pkg::bus_req_t bus_req,
    output logic [31:0]          rd_data,
    output logic                 rd_valid,
    output logic [9:0]           ledr,
    output board_io_pkg::hex_t   hex
);

    board_io_pkg::sw_t                sw_db;
    board_io_pkg::key_t               key_pressed;
    board_io_pkg::key_t               key_db;
    io_bus_pkg::input_sample_t        sample;
    logic [`BOARD_IO_RED_WIDTH-1:0]   red_leds;
    logic [`BOARD_IO_GREEN_WIDTH-1:0] green_leds;
    logic [3:0]                       addr_nibble;

    input_debouncer #(
        .payload_t (board_io_pkg::sw_t)
    ) u_sw_debounce (
        .clk   (clk),
        .rst   (rst),
        .raw   (sw),
        .clean (sw_db)
    );

    // debounced active high, so released keys come out of reset as zero.
    input_debouncer #(
        .payload_t (board_io_pkg::key_t)
    ) u_key_debounce (
        .clk   (clk),
        .rst   (rst),
        .raw   (~key),
        .clean (key_pressed)
    );

    // back to pin polarity for the sample.
    assign key_db = ~key_pressed;
    assign sample = '{sw: sw_db, key: key_db};

    io_register_file u_io_registers (
        .clk         (clk),
        .rst         (rst),
        .bus_req     (bus_req),
        .sample      (sample),
        .rd_data     (rd_data),
        .rd_valid    (rd_valid),
        .red_leds    (red_leds),
        .green_leds  (green_leds),
        .addr_nibble (addr_nibble)
    );

    // the board has ten leds, the top one unused.
    assign ledr = {1'b0, green_leds};

    seven_segment_bank u_display (
        .clk         (clk),
        .rst         (rst),
        .red_leds    (red_leds),
        .addr_nibble (addr_nibble),
        .hex         (hex)
    );

endmodule

// ==== tb/de0_cv_io_chk.sv ====
`timescale 1ns/1ps
`include "board_io_cfg.svh"

module de0_cv_io_chk (
    input logic                 clk,
    input logic                 rst,
    input io_bus_pkg::bus_req_t bus_req,
    input logic [31:0]          rd_data,
    input logic                 rd_valid,
    input logic [9:0]           ledr,
    input board_io_pkg::hex_t   hex
);

    localparam board_io_pkg::hex_t ALL_ZERO_GLYPHS = {6{7'b100_0000}};

    int   reset_fails = 0;
    int   strobe_fails = 0;
    int   green_fails = 0;
    int   unmapped_fails = 0;
    int   failures;
    logic read_req;
    logic green_write;
    logic mapped;

    assign read_req    = bus_req.valid && !bus_req.write;
    assign green_write = bus_req.valid && bus_req.write
                         && bus_req.addr == `BOARD_IO_ADDR_GREEN_LEDS;
    assign mapped      = bus_req.addr == `BOARD_IO_ADDR_RED_LEDS
                         || bus_req.addr == `BOARD_IO_ADDR_GREEN_LEDS
                         || bus_req.addr == `BOARD_IO_ADDR_SWITCHES
                         || bus_req.addr == `BOARD_IO_ADDR_BUTTONS;
    assign failures    = reset_fails + strobe_fails + green_fails + unmapped_fails;

    // first cycle out of reset.
    reset_state: assert property (@(posedge clk)
        $fell(rst) |-> !rd_valid && ledr == '0 && hex == ALL_ZERO_GLYPHS)
        else begin
            reset_fails++;
            $error("outputs left reset with wrong values");
        end

    // one strobe per read, nothing in between.
    read_strobe: assert property (@(posedge clk) disable iff (rst)
        !$past(rst) |-> rd_valid == $past(read_req))
        else begin
            strobe_fails++;
            $error("rd_valid does not pulse exactly one cycle after each read");
        end

    green_follow: assert property (@(posedge clk) disable iff (rst)
        !$past(rst) && $past(green_write)
        |-> ledr == {1'b0, $past(bus_req.wdata[`BOARD_IO_GREEN_WIDTH-1:0])})
        else begin
            green_fails++;
            $error("ledr did not take the green write one cycle later");
        end

    unmapped_zero: assert property (@(posedge clk) disable iff (rst)
        !$past(rst) && $past(read_req && !mapped) |-> rd_data == 32'h0)
        else begin
            unmapped_fails++;
            $error("read of an unmapped address returned nonzero data");
        end

endmodule

bind de0_cv_io de0_cv_io_chk u_chk (
    .clk      (clk),
    .rst      (rst),
    .bus_req  (bus_req),
    .rd_data  (rd_data),
    .rd_valid (rd_valid),
    .ledr     (ledr),
    .hex      (hex)
);

// ==== tb/tb_de0_cv_io.sv ====
`timescale 1ns/1ps
`include "board_io_cfg.svh"

module tb_de0_cv_io;

    localparam int          HOLD_CYCLES = `BOARD_IO_DEBOUNCE_CYCLES + 2;
    localparam int          GREEN_BURST = 16;
    localparam int          RED_WRITES = 20;
    localparam int          INPUT_ROUNDS = 50;
    // roughly twice the stimulus, which the input rounds dominate.
    localparam int          TIMEOUT_CYCLES = 4000;
    localparam logic [31:0] ADDR_UNMAPPED = 32'h1f80_0010;

    // active-low gfedcba patterns, 0 to F.
    localparam board_io_pkg::seg_t GLYPHS [16] = '{
        7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
        7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0e
    };

    logic                 clk = 1'b0;
    logic                 rst;
    board_io_pkg::sw_t    sw;
    board_io_pkg::key_t   key;
    io_bus_pkg::bus_req_t bus_req;
    logic [31:0]          rd_data;
    logic                 rd_valid;
    logic [9:0]           ledr;
    board_io_pkg::hex_t   hex;

    int                 mismatches = 0;
    int                 cycles = 0;
    logic [31:0]        rng_state = 32'hab91;
    logic [17:0]        red_model = '0;
    logic [8:0]         green_model = '0;
    board_io_pkg::sw_t  sw_model = '0;
    board_io_pkg::key_t pressed_model = '0;

    de0_cv_io u_de0_cv_io (
        .clk      (clk),
        .rst      (rst),
        .sw       (sw),
        .key      (key),
        .bus_req  (bus_req),
        .rd_data  (rd_data),
        .rd_valid (rd_valid),
        .ledr     (ledr),
        .hex      (hex)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: stimulus still running after %0d cycles", cycles);
            $display("TB FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    // display layout: address nibble, then red bits 17 down to 0.
    function automatic board_io_pkg::hex_t expected_hex(input logic [3:0] nibble,
                                                        input logic [17:0] red);
        board_io_pkg::hex_t h;
        h.digit5 = GLYPHS[nibble];
        h.digit4 = GLYPHS[{2'b00, red[17:16]}];
        h.digit3 = GLYPHS[red[15:12]];
        h.digit2 = GLYPHS[red[11:8]];
        h.digit1 = GLYPHS[red[7:4]];
        h.digit0 = GLYPHS[red[3:0]];
        return h;
    endfunction

    function automatic io_bus_pkg::bus_req_t make_req(input logic write,
                                                     input logic [31:0] addr,
                                                     input logic [31:0] wdata);
        io_bus_pkg::bus_req_t req;
        req.valid = 1'b1;
        req.write = write;
        req.addr  = addr;
        req.wdata = wdata;
        return req;
    endfunction

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        assert (actual === expected) else begin
            mismatches++;
            $display("** Error at %0t ns: %s expected %0h, got %0h",
                     $time, name, expected, actual);
        end
    endtask

    // all bus tasks start and end on a rising edge.
    task automatic bus_write(input logic [31:0] addr, input logic [31:0] wdata);
        bus_req <= make_req(1'b1, addr, wdata);
        @(posedge clk);
        bus_req <= '0;
    endtask

    task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
        bus_req <= make_req(1'b0, addr, 32'h0);
        @(posedge clk);
        bus_req <= '0;
        @(negedge clk);
        check_value("rd_valid", 64'(rd_valid), 64'd1);
        data = rd_data;
        @(posedge clk);
    endtask

    task automatic read_expect(input string name, input logic [31:0] addr,
                               input logic [31:0] expected);
        logic [31:0] data;
        bus_read(addr, data);
        check_value(name, 64'(data), 64'(expected));
    endtask

    // write then read back in the next cycle, display two cycles after the write.
    task automatic red_write_test(input logic [31:0] wdata);
        bus_req <= make_req(1'b1, `BOARD_IO_ADDR_RED_LEDS, wdata);
        @(posedge clk);
        bus_req <= make_req(1'b0, `BOARD_IO_ADDR_RED_LEDS, 32'h0);
        red_model = wdata[17:0];
        @(posedge clk);
        bus_req <= '0;
        @(negedge clk);
        check_value("rd_data", 64'(rd_data), 64'(red_model));
        check_value("hex", 64'(hex), 64'(expected_hex(4'h1, red_model)));
        @(posedge clk);
    endtask

    task automatic green_burst_test();
        logic [31:0] wdata [GREEN_BURST];
        for (int k = 0; k < GREEN_BURST; k++) begin
            wdata[k] = next_random();
        end
        bus_req <= make_req(1'b1, `BOARD_IO_ADDR_GREEN_LEDS, wdata[0]);
        for (int k = 1; k <= GREEN_BURST; k++) begin
            @(posedge clk);
            if (k < GREEN_BURST) begin
                bus_req <= make_req(1'b1, `BOARD_IO_ADDR_GREEN_LEDS, wdata[k]);
            end else begin
                bus_req <= '0;
            end
            green_model = wdata[k-1][8:0];
            @(negedge clk);
            check_value("ledr", 64'(ledr), 64'({1'b0, green_model}));
        end
        @(posedge clk);
    endtask

    task automatic hold_inputs(input board_io_pkg::sw_t pattern,
                               input board_io_pkg::key_t pressed);
        sw <= pattern;
        key <= ~pressed;
        sw_model = pattern;
        pressed_model = pressed;
        repeat (HOLD_CYCLES) @(posedge clk);
        read_expect("switches", `BOARD_IO_ADDR_SWITCHES, 32'(sw_model));
        read_expect("buttons", `BOARD_IO_ADDR_BUTTONS, 32'(pressed_model));
    endtask

    // back-to-back reads, switches and buttons in turn, each checked a cycle later.
    task automatic watch_inputs(input int count);
        logic [31:0] addrs [2];
        logic [31:0] expected [2];
        string       names [2];
        int          sel;
        addrs[0] = `BOARD_IO_ADDR_SWITCHES;
        addrs[1] = `BOARD_IO_ADDR_BUTTONS;
        expected[0] = 32'(sw_model);
        expected[1] = 32'(pressed_model);
        names[0] = "switches during glitch";
        names[1] = "buttons during glitch";
        bus_req <= make_req(1'b0, addrs[0], 32'h0);
        for (int c = 1; c <= count; c++) begin
            @(posedge clk);
            if (c < count) begin
                bus_req <= make_req(1'b0, addrs[c % 2], 32'h0);
            end else begin
                bus_req <= '0;
            end
            sel = (c - 1) % 2;
            @(negedge clk);
            check_value("rd_valid", 64'(rd_valid), 64'd1);
            check_value(names[sel], 64'(rd_data), 64'(expected[sel]));
        end
        @(posedge clk);
    endtask

    // every bit flips for three cycles, too short to pass.
    task automatic glitch_inputs();
        sw <= ~sw_model;
        key <= pressed_model;
        repeat (3) @(posedge clk);
        sw <= sw_model;
        key <= ~pressed_model;
        watch_inputs(HOLD_CYCLES + 3);
    endtask

    task automatic nibble_test();
        read_expect("rd_data unmapped", 32'ha000_0000, 32'h0);
        @(negedge clk);
        check_value("hex.digit5", 64'(hex.digit5), 64'(GLYPHS[4'ha]));
        @(posedge clk);
    endtask

    initial begin
        logic [31:0] rnd;
        int          assertion_failures;
        rst = 1'b1;
        sw = '0;
        key = '1;
        bus_req = '0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value("rd_valid", 64'(rd_valid), 64'd0);
        check_value("ledr", 64'(ledr), 64'd0);
        check_value("hex", 64'(hex), 64'(expected_hex(4'h0, 18'h0)));
        @(posedge clk);

        for (int n = 0; n < RED_WRITES; n++) begin
            red_write_test(next_random());
        end
        green_burst_test();
        nibble_test();

        for (int n = 0; n < INPUT_ROUNDS; n++) begin
            rnd = next_random();
            hold_inputs(rnd[9:0], rnd[13:10]);
            glitch_inputs();
        end

        // input registers ignore writes.
        bus_write(`BOARD_IO_ADDR_SWITCHES, ~32'(sw_model));
        read_expect("switches after write", `BOARD_IO_ADDR_SWITCHES, 32'(sw_model));
        bus_write(`BOARD_IO_ADDR_BUTTONS, ~32'(pressed_model));
        read_expect("buttons after write", `BOARD_IO_ADDR_BUTTONS, 32'(pressed_model));
        read_expect("red read", `BOARD_IO_ADDR_RED_LEDS, 32'(red_model));
        read_expect("green read", `BOARD_IO_ADDR_GREEN_LEDS, 32'(green_model));
        bus_write(ADDR_UNMAPPED, next_random());
        read_expect("unmapped read", ADDR_UNMAPPED, 32'h0);
        read_expect("unmapped low read", 32'h0000_0000, 32'h0);
        check_value("ledr", 64'(ledr), 64'({1'b0, green_model}));

        repeat (4) @(posedge clk);
        assertion_failures = u_de0_cv_io.u_chk.failures;
        $display("checks done: %0d value mismatches, %0d assertion failures",
                 mismatches, assertion_failures);
        if (mismatches == 0 && assertion_failures == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+src
src/board_io_pkg.sv
src/io_bus_pkg.sv
src/input_debouncer.sv
src/io_register_file.sv
src/seven_segment_bank.sv
src/de0_cv_io.sv
tb/de0_cv_io_chk.sv
tb/tb_de0_cv_io.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the Verilator model of tb_de0_cv_io, run it, and scan the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
    --top-module tb_de0_cv_io \
    -f src.f \
    -o sim_tb_de0_cv_io
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

# the error limit lets the run reach its closing summary after an assertion fires
./obj_dir/sim_tb_de0_cv_io +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TB FAILED" "$LOG"; then
    echo "simulation reported a failure, see $LOG"
    exit 1
fi

echo "simulation finished without failures"
exit 0
